// File: verilog/track_consts.svh
`ifndef TRACK_CONSTS_SVH
`define TRACK_CONSTS_SVH

// --------------------
// clock
// --------------------
`define CLK_HZ      50000000     // 50 MHz system clock

// --------------------
// tracking window, adc counts
// --------------------
`define X0          10000        // reference position
`define DX1         55           // dead band, |dev| <= this stops the drive
`define DX2         300          // saturation, |dev| >= this runs at max rate

// step rate limits, Hz
`define F_MIN       6000
`define F_MAX       50000

// integer slope of the rate law, Hz per count
`define K_SLOPE     ((`F_MAX - `F_MIN) / (`DX2 - `DX1))

// --------------------
// field widths
// --------------------
`define SAMPLE_W    37           // adc word
`define FREQ_W      17           // step frequency
`define PERIOD_W    17           // period in clocks
`define DIV_CNT_W   5            // quotient bit index, 0..PERIOD_W-1
`define DIVIDEND_W  (`PERIOD_W + `FREQ_W)  // room for CLK_HZ

`endif

// File: verilog/track_types_pkg.sv
`include "track_consts.svh"

// measurement side, adc word through to the period count
package track_types_pkg;

  // raw adc word, unsigned
  typedef logic [`SAMPLE_W-1:0] sample_t;

  // deviation from the reference position
  typedef struct packed
  {
    logic [`SAMPLE_W-1:0] magnitude;  // |sample - X0|
    logic                 dir;        // 1 when sample above X0
    logic                 active;     // outside dead band and mode on
  } deviation_t;

  // step rate request into the divider
  typedef struct packed
  {
    logic [`FREQ_W-1:0] freq;   // Hz, F_MIN..F_MAX
    logic               dir;
    logic               active;
  } rate_req_t;

  // step period in clk_50MHz cycles
  typedef logic [`PERIOD_W-1:0] period_t;

endpackage

// File: verilog/drive_types_pkg.sv
// drive side, command word and the two state machines
package drive_types_pkg;

  // what the pulse generator runs from
  typedef struct packed
  {
    track_types_pkg::period_t period;  // clocks per step
    logic                     dir;     // motor direction
    logic                     active;  // 0 stops at the next boundary
  } drive_cmd_t;

  // period divider
  typedef enum logic
  {
    div_idle,
    div_busy      // one quotient bit per clock
  } div_state_e;

  // step pulse generator
  typedef enum logic
  {
    pulse_stopped,
    pulse_running
  } pulse_state_e;

endpackage

// File: verilog/error_stage.sv
`timescale 1ns/100ps
`include "track_consts.svh"

// sample minus reference, split into magnitude and direction
module error_stage
(
  input  logic                        clk_50MHz,
  input  logic                        reset,
  input  track_types_pkg::sample_t    sample,
  input  logic                        sample_valid,
  input  logic                        mode_enable,
  output track_types_pkg::deviation_t dev,
  output logic                        dev_valid
);

  // --------------------
  // deviation, combinational
  // --------------------
  logic [`SAMPLE_W:0]   diff;       // two's complement, msb is sign
  logic [`SAMPLE_W:0]   diff_neg;   // negated diff
  logic                 below;      // sample under the reference
  logic                 above;      // sample over the reference
  logic [`SAMPLE_W-1:0] magnitude;
  logic                 outside;    // past the dead band

  assign diff     = {1'b0, sample} - `X0;  // one spare bit for the sign
  assign diff_neg = -diff;
  assign below    = diff[`SAMPLE_W];
  assign above    = ~below & (|diff);      // zero deviation counts as dir 0

  // abs value, fits in SAMPLE_W bits
  assign magnitude = below ? diff_neg[`SAMPLE_W-1:0] : diff[`SAMPLE_W-1:0];

  assign outside = magnitude > `DX1;       // equal to DX1 still stops

  // --------------------
  // output register
  // --------------------
  always_ff @(posedge clk_50MHz)
  begin
    if (reset)
    begin
      dev_valid <= 1'b0;
    end
    else
    begin
      dev_valid <= sample_valid;           // one cycle latency
    end
  end

  // payload, loaded on every valid sample
  always_ff @(posedge clk_50MHz)
  begin
    if (sample_valid)
    begin
      dev.magnitude <= magnitude;
      dev.dir       <= above;
      dev.active    <= mode_enable & outside;  // mode gate + dead band
    end
  end

endmodule

// File: verilog/rate_stage.sv
`timescale 1ns/100ps
`include "track_consts.svh"

// linear rate law, F_MIN at the dead band edge up to F_MAX at saturation
module rate_stage
(
  input  logic                        clk_50MHz,
  input  logic                        reset,
  input  track_types_pkg::deviation_t dev,
  input  logic                        dev_valid,
  output track_types_pkg::rate_req_t  req,
  output logic                        req_valid
);

  logic [`SAMPLE_W-1:0] excess;    // counts past the dead band
  logic [`SAMPLE_W-1:0] lin_wide;  // F_MIN + K*excess, full width
  logic                 sat;       // at or past DX2
  logic [`FREQ_W-1:0]   freq;

  // only meaningful when active, i.e. magnitude > DX1
  assign excess   = dev.magnitude - `SAMPLE_W'(`DX1);
  assign lin_wide = `SAMPLE_W'(`F_MIN) + excess * `SAMPLE_W'(`K_SLOPE);

  assign sat      = dev.magnitude >= `DX2;

  // --------------------
  // clamp to both limits
  // --------------------
  always_comb
  begin
    if (!dev.active)
    begin
      freq = `FREQ_W'(`F_MIN);             // stopped, park at the low rate
    end
    else if (sat)
    begin
      freq = `FREQ_W'(`F_MAX);
    end
    else
    begin
      freq = lin_wide[`FREQ_W-1:0];        // below F_MAX here, fits
    end
  end

  // --------------------
  // output register
  // --------------------
  always_ff @(posedge clk_50MHz)
  begin
    if (reset)
    begin
      req_valid <= 1'b0;
    end
    else
    begin
      req_valid <= dev_valid;
    end
  end

  always_ff @(posedge clk_50MHz)
  begin
    if (dev_valid)
    begin
      req.freq   <= freq;
      req.dir    <= dev.dir;               // dir and active ride along
      req.active <= dev.active;
    end
  end

endmodule

// File: verilog/period_divider.sv
`timescale 1ns/100ps
`include "track_consts.svh"

// period = CLK_HZ / freq, restoring shift-subtract, one bit per clock
// 18 clocks from req_valid to cmd_valid when idle
module period_divider
(
  input  logic                        clk_50MHz,
  input  logic                        reset,
  input  track_types_pkg::rate_req_t  req,
  input  logic                        req_valid,
  output drive_types_pkg::drive_cmd_t cmd,
  output logic                        cmd_valid
);

  // dividend, top FREQ_W bits seed the remainder
  localparam logic [`DIVIDEND_W-1:0] dividend = `DIVIDEND_W'(`CLK_HZ);

  drive_types_pkg::div_state_e state;

  logic [`FREQ_W-1:0]        divisor;
  logic [`FREQ_W-1:0]        rem;       // always below divisor
  logic [`FREQ_W:0]          trial;     // rem shifted, next dividend bit in
  logic [`FREQ_W:0]          trial_sub;
  logic                      q_bit;
  logic [`FREQ_W-1:0]        rem_next;
  logic [`PERIOD_W-2:0]      quot;      // bits so far, last one added at the end
  logic [`DIV_CNT_W-1:0]     bit_cnt;   // dividend bit in use
  logic                      cur_dir;
  logic                      cur_active;

  // one-deep pending slot, newest wins
  track_types_pkg::rate_req_t pend_req;
  logic                       pend_valid;
  track_types_pkg::rate_req_t load_req;

  logic last;   // final quotient bit this cycle
  logic start;  // take a new request this edge

  // --------------------
  // one division step
  // --------------------
  assign trial     = {rem, dividend[bit_cnt]};
  assign trial_sub = trial - {1'b0, divisor};
  assign q_bit     = trial >= {1'b0, divisor};
  assign rem_next  = q_bit ? trial_sub[`FREQ_W-1:0] : trial[`FREQ_W-1:0];

  assign last     = (state == drive_types_pkg::div_busy) && (bit_cnt == '0);
  assign start    = ((state == drive_types_pkg::div_idle) || last) && (req_valid || pend_valid);
  assign load_req = req_valid ? req : pend_req;  // fresh request beats pending

  // --------------------
  // control
  // --------------------
  always_ff @(posedge clk_50MHz)
  begin
    if (reset)
    begin
      state      <= drive_types_pkg::div_idle;
      pend_valid <= 1'b0;
      cmd_valid  <= 1'b0;
    end
    else
    begin
      cmd_valid <= last;
      if (start)
        state <= drive_types_pkg::div_busy;  // back to back if work waits
      else if (last)
        state <= drive_types_pkg::div_idle;
      if (start)
        pend_valid <= 1'b0;                  // slot consumed or overtaken
      else if (req_valid)
        pend_valid <= 1'b1;                  // busy, park it
    end
  end

  // --------------------
  // datapath
  // --------------------
  always_ff @(posedge clk_50MHz)
  begin
    if (req_valid && !start)
      pend_req <= req;
    if (start)
    begin
      divisor    <= load_req.freq;
      rem        <= dividend[`DIVIDEND_W-1:`PERIOD_W];
      bit_cnt    <= `DIV_CNT_W'(`PERIOD_W - 1);
      cur_dir    <= load_req.dir;
      cur_active <= load_req.active;
    end
    else if (state == drive_types_pkg::div_busy)
    begin
      rem     <= rem_next;
      quot    <= {quot[`PERIOD_W-3:0], q_bit};
      bit_cnt <= bit_cnt - 1'b1;
    end
    if (last)
    begin
      cmd.period <= {quot, q_bit};           // lsb straight from this step
      cmd.dir    <= cur_dir;
      cmd.active <= cur_active;
    end
  end

endmodule

// File: verilog/step_pulse_gen.sv
`timescale 1ns/100ps

// step pulse generator, one clk wide step every period
// commands only take effect at a period boundary
module step_pulse_gen
(
  input  logic                        clk_50MHz,
  input  logic                        reset,
  input  drive_types_pkg::drive_cmd_t cmd,
  input  logic                        cmd_valid,
  output logic                        step,
  output logic                        dir,
  output logic                        drive_enable
);

  drive_types_pkg::pulse_state_e state;

  track_types_pkg::period_t    cnt;         // clocks into the current period
  track_types_pkg::period_t    cur_period;
  drive_types_pkg::drive_cmd_t pend_cmd;    // waits for the boundary
  logic                        pend_valid;
  drive_types_pkg::drive_cmd_t next_cmd;
  logic                        have_next;
  logic                        wrap;        // last clock of the period

  assign next_cmd  = cmd_valid ? cmd : pend_cmd;  // newest command wins
  assign have_next = cmd_valid | pend_valid;
  assign wrap      = ({1'b0, cnt} + 1'b1) >= {1'b0, cur_period};

  // --------------------
  // state machine
  // --------------------
  always_ff @(posedge clk_50MHz)
  begin
    if (reset)
    begin
      state        <= drive_types_pkg::pulse_stopped;
      cnt          <= '0;
      pend_valid   <= 1'b0;
      step         <= 1'b0;
      dir          <= 1'b0;
      drive_enable <= 1'b0;
    end
    else
    begin
      step <= 1'b0;                          // pulse lasts one clock
      case (state)
        drive_types_pkg::pulse_stopped:
        begin
          pend_valid <= 1'b0;
          if (cmd_valid && cmd.active)       // load at once
          begin
            state        <= drive_types_pkg::pulse_running;
            cnt          <= '0;
            dir          <= cmd.dir;
            drive_enable <= 1'b1;
          end
        end
        drive_types_pkg::pulse_running:
        begin
          if (wrap)
          begin
            cnt        <= '0;
            pend_valid <= 1'b0;
            if (have_next && !next_cmd.active)
            begin
              state        <= drive_types_pkg::pulse_stopped;  // no more steps
              drive_enable <= 1'b0;
            end
            else
            begin
              step <= 1'b1;
              if (have_next)
                dir <= next_cmd.dir;
            end
          end
          else
          begin
            cnt <= cnt + 1'b1;
            if (cmd_valid)
              pend_valid <= 1'b1;            // hold till the boundary
          end
        end
        default: state <= drive_types_pkg::pulse_stopped;
      endcase
    end
  end

  // period and pending command, payload only
  always_ff @(posedge clk_50MHz)
  begin
    if (cmd_valid)
      pend_cmd <= cmd;
    if (state == drive_types_pkg::pulse_stopped && cmd_valid)
      cur_period <= cmd.period;
    else if (state == drive_types_pkg::pulse_running && wrap && have_next)
      cur_period <= next_cmd.period;         // adopt at the boundary
  end

endmodule

// File: verilog/tracker_top.sv
`timescale 1ns/100ps

// tracking drive, error -> rate -> divider -> pulse gen
module tracker_top
(
  input  logic                     clk_50MHz,
  input  logic                     reset,
  input  track_types_pkg::sample_t sample,
  input  logic                     sample_valid,  // one clk strobe
  input  logic                     mode_enable,
  output logic                     step,
  output logic                     dir,
  output logic                     drive_enable,
  output track_types_pkg::period_t period,
  output logic                     period_valid   // new period computed
);

  // --------------------
  // stage links
  // --------------------
  track_types_pkg::deviation_t dev;
  logic                        dev_valid;
  track_types_pkg::rate_req_t  req;
  logic                        req_valid;
  drive_types_pkg::drive_cmd_t cmd;
  logic                        cmd_valid;   // 20 clks after sample_valid

  error_stage u_error_stage
  (
    .clk_50MHz    (clk_50MHz),
    .reset        (reset),
    .sample       (sample),
    .sample_valid (sample_valid),
    .mode_enable  (mode_enable),
    .dev          (dev),
    .dev_valid    (dev_valid)
  );

  rate_stage u_rate_stage
  (
    .clk_50MHz (clk_50MHz),
    .reset     (reset),
    .dev       (dev),
    .dev_valid (dev_valid),
    .req       (req),
    .req_valid (req_valid)
  );

  period_divider u_period_divider
  (
    .clk_50MHz (clk_50MHz),
    .reset     (reset),
    .req       (req),
    .req_valid (req_valid),
    .cmd       (cmd),
    .cmd_valid (cmd_valid)
  );

  step_pulse_gen u_step_pulse_gen
  (
    .clk_50MHz    (clk_50MHz),
    .reset        (reset),
    .cmd          (cmd),
    .cmd_valid    (cmd_valid),
    .step         (step),
    .dir          (dir),
    .drive_enable (drive_enable)
  );

  // period breakout for monitoring
  assign period       = cmd.period;
  assign period_valid = cmd_valid;

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/100ps

// 50 MHz clock and a reset held for the first two rising edges
module tb_clock
(
  output logic clk_50MHz,
  output logic reset
);

  initial
  begin
    clk_50MHz = 1'b0;
    forever #10 clk_50MHz = ~clk_50MHz;  // 20 ns period
  end

  initial
  begin
    reset = 1'b1;
    repeat (2) @(posedge clk_50MHz);
    reset <= 1'b0;                       // released on the second edge
  end

endmodule

// File: bench/tracker_tb.sv
`timescale 1ns/100ps
`include "track_consts.svh"

// tracker testbench, lfsr stimulus checked against a behavioral model
module tracker_tb;

  logic                     clk_50MHz;
  logic                     reset;
  track_types_pkg::sample_t sample;
  logic                     sample_valid;
  logic                     mode_enable;
  logic                     step;
  logic                     dir;
  logic                     drive_enable;
  track_types_pkg::period_t period;
  logic                     period_valid;

  logic [1:0]  exp_tag;              // 0 no result, 1 timed, 2 untimed
  logic [31:0] lfsr        = 32'd1339;
  int          cyc         = 0;      // rising edges seen
  int          last_pv_cyc = 0;

  drive_types_pkg::drive_cmd_t exp_q[$];  // expected divider results, in order
  int                          lat_q[$];  // arrival cycle, -1 when untimed

  tb_clock u_clock (.clk_50MHz(clk_50MHz), .reset(reset));

  tracker_top dut
  (
    .clk_50MHz    (clk_50MHz),
    .reset        (reset),
    .sample       (sample),
    .sample_valid (sample_valid),
    .mode_enable  (mode_enable),
    .step         (step),
    .dir          (dir),
    .drive_enable (drive_enable),
    .period       (period),
    .period_valid (period_valid)
  );

  // --------------------
  // random source
  // --------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);  // galois, taps 32 31 29 1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);        // one step per bit
    end
  endtask

  // dead band, between bands, saturated, or one of the band edges
  task automatic pick_sample(output track_types_pkg::sample_t s, output logic mode);
    logic [31:0] kind;
    logic [31:0] sign;
    logic [31:0] r;
    logic [31:0] m;
    logic [31:0] mag;
    take_bits(2, kind);
    take_bits(1, sign);
    case (kind[1:0])
      2'd0:
      begin
        take_bits(6, r);
        mag = r % (`DX1 + 1);
      end
      2'd1:
      begin
        take_bits(8, r);
        mag = `DX1 + 1 + r % (`DX2 - `DX1 - 1);
      end
      2'd2:
      begin
        take_bits(10, r);
        mag = `DX2 + r;
      end
      default:
      begin
        take_bits(2, r);
        mag = (r[1:0] == 2'd0) ? `DX1 : (r[1:0] == 2'd1) ? `DX1 + 1 :
              (r[1:0] == 2'd2) ? `DX2 - 1 : `DX2;
      end
    endcase
    take_bits(3, m);
    mode = (m[2:0] != 3'd0);         // low about one time in eight
    s    = sign[0] ? `SAMPLE_W'(`X0 + mag) : `SAMPLE_W'(`X0 - mag);
  endtask

  // --------------------
  // reference model
  // --------------------
  function automatic drive_types_pkg::drive_cmd_t model_cmd(
    input track_types_pkg::sample_t s, input logic mode);
    drive_types_pkg::drive_cmd_t c;
    longint                      mag;
    longint                      freq;
    mag      = (s > `X0) ? longint'(s) - `X0 : `X0 - longint'(s);
    c.dir    = s > `X0;
    c.active = mode && (mag > `DX1);
    if (!c.active)
      freq = `F_MIN;
    else if (mag >= `DX2)
      freq = `F_MAX;
    else
      freq = `F_MIN + `K_SLOPE * (mag - `DX1);
    c.period = track_types_pkg::period_t'(`CLK_HZ / freq);  // truncated
    return c;
  endfunction

  // --------------------
  // checks
  // --------------------
  task automatic stop_run();
    $display("sim failed");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_period(input track_types_pkg::period_t got,
                              input track_types_pkg::period_t exp);
    if (got !== exp)
    begin
      $display("error at %0t: period got %0d expected %0d", $time, got, exp);
      stop_run();
    end
  endtask

  // dir and drive_enable against the model
  task automatic check_drive(input drive_types_pkg::drive_cmd_t got,
                             input drive_types_pkg::drive_cmd_t exp);
    if (got.dir !== exp.dir)
    begin
      $display("error at %0t: dir got %0b expected %0b", $time, got.dir, exp.dir);
      stop_run();
    end
    else if (got.active !== exp.active)
    begin
      $display("error at %0t: drive_enable got %0b expected %0b", $time,
               got.active, exp.active);
      stop_run();
    end
  endtask

  task automatic check_step_gap(input track_types_pkg::period_t got,
                                input track_types_pkg::period_t exp);
    if (got !== exp)
    begin
      $display("error at %0t: step gap got %0d expected %0d", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_arrival(input int got, input int exp);
    if (got != exp)
    begin
      $display("error at %0t: period_valid cycle got %0d expected %0d", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_strobe(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("error at %0t: %s got %0b expected %0b", $time, name, got, exp);
      stop_run();
    end
  endtask

  // --------------------
  // result monitor
  // --------------------
  always @(posedge clk_50MHz)
  begin : monitor
    drive_types_pkg::drive_cmd_t exp_cmd;
    int                          exp_at;
    cyc = cyc + 1;
    if (!reset && sample_valid && exp_tag != 2'd0)
    begin
      exp_q.push_back(model_cmd(sample, mode_enable));
      lat_q.push_back((exp_tag == 2'd1) ? cyc + 20 : -1);  // sample to cmd, 20 clks
    end
    if (!reset && period_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("period_valid arrived with no sample waiting for a result");
        stop_run();
      end
      else
      begin
        exp_cmd = exp_q.pop_front();
        exp_at  = lat_q.pop_front();
        if (exp_at >= 0)
          check_arrival(cyc, exp_at);
        check_period(period, exp_cmd.period);
        last_pv_cyc = cyc;
      end
    end
  end

  // --------------------
  // drive and wait helpers
  // --------------------
  task automatic send_sample(input track_types_pkg::sample_t s, input logic mode,
                             input logic [1:0] tag);
    @(posedge clk_50MHz);
    sample       <= s;
    mode_enable  <= mode;
    sample_valid <= 1'b1;
    exp_tag      <= tag;
    @(posedge clk_50MHz);
    sample_valid <= 1'b0;
    exp_tag      <= 2'd0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_50MHz);
  endtask

  task automatic wait_reset(input int limit);
    int n;
    n = 0;
    while (reset !== 1'b0)
    begin
      if (n >= limit)
      begin
        $display("timeout, reset never went low");
        stop_run();
      end
      @(negedge clk_50MHz);
      n++;
    end
    @(negedge clk_50MHz);
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    @(negedge clk_50MHz);
    while (exp_q.size() != 0)
    begin
      if (n >= limit)
      begin
        $display("timeout, %0d expected periods never arrived", exp_q.size());
        stop_run();
      end
      @(negedge clk_50MHz);
      n++;
    end
  endtask

  // now_ok looks at the current cycle first
  task automatic wait_step(input int limit, input logic now_ok, output int at);
    int n;
    n = 0;
    if (!now_ok)
      @(negedge clk_50MHz);
    while (step !== 1'b1)
    begin
      if (n >= limit)
      begin
        $display("timeout, no step pulse within %0d cycles", limit);
        stop_run();
      end
      @(negedge clk_50MHz);
      n++;
    end
    at = cyc;
  endtask

  task automatic wait_disabled(input int limit);
    int n;
    n = 0;
    while (drive_enable !== 1'b0)
    begin
      if (step === 1'b1)
      begin
        $display("step pulse came after a stop command had arrived");
        stop_run();
      end
      else if (n >= limit)
      begin
        $display("timeout, drive_enable stayed high after a stop command");
        stop_run();
      end
      @(negedge clk_50MHz);
      n++;
    end
  endtask

  task automatic quiet_window(input int cycles);
    for (int i = 0; i < cycles; i++)
    begin
      @(negedge clk_50MHz);
      if (step === 1'b1)
      begin
        $display("step pulse while the drive is stopped");
        stop_run();
      end
    end
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial
  begin : stimulus
    track_types_pkg::sample_t    s;
    logic                        m;
    drive_types_pkg::drive_cmd_t exp_run;
    drive_types_pkg::drive_cmd_t got;
    track_types_pkg::period_t    prev_p;
    int                          at;
    int                          prev_at;
    logic [31:0]                 r;
    int                          edge_off [4];

    sample       = '0;
    sample_valid = 1'b0;
    mode_enable  = 1'b0;
    exp_tag      = 2'd0;
    edge_off     = '{`DX2, -`DX2 - 700, `DX1 + 1, -`DX1};

    // quiet outputs out of reset
    wait_reset(10);
    check_strobe("step", step, 1'b0);
    check_strobe("period_valid", period_valid, 1'b0);
    got        = '0;
    got.dir    = dir;
    got.active = drive_enable;
    check_drive(got, '0);

    // random stream, 24 clks apart, then the rate law edges
    for (int i = 0; i < 32; i++)
    begin
      pick_sample(s, m);
      send_sample(s, m, 2'd1);
      idle_cycles(22);
    end
    for (int k = 0; k < 4; k++)
    begin
      send_sample(`SAMPLE_W'(`X0 + edge_off[k]), 1'b1, 2'd1);
      idle_cycles(22);
    end
    wait_drain(40);

    // burst into a busy divider, middle one overwritten in the pending slot
    take_bits(8, r);
    send_sample(`SAMPLE_W'(`X0 + `DX1 + 1 + r % 200), 1'b1, 2'd1);
    send_sample(`SAMPLE_W'(`X0 - `DX2 - r), 1'b1, 2'd0);
    send_sample(`SAMPLE_W'(`X0 - `DX1 - 30), 1'b1, 2'd2);
    wait_drain(60);
    idle_cycles(40);                     // a third strobe hits an empty queue

    // mode low stops the drive at the boundary
    s = `SAMPLE_W'(`X0 + 200);
    send_sample(s, 1'b0, 2'd1);
    wait_drain(30);
    wait_disabled(8400);
    quiet_window(9000);

    // start from stopped, first step one period after the load
    take_bits(8, r);
    s       = `SAMPLE_W'(`X0 + `DX1 + 1 + r % (`DX2 - `DX1 - 1));
    exp_run = model_cmd(s, 1'b1);
    send_sample(s, 1'b1, 2'd1);
    wait_drain(30);
    prev_at = last_pv_cyc;
    wait_step(exp_run.period + 4, 1'b1, at);
    check_step_gap(track_types_pkg::period_t'(at - prev_at), exp_run.period);
    got.dir    = dir;
    got.active = drive_enable;
    check_drive(got, exp_run);
    repeat (3)
    begin
      prev_at = at;
      wait_step(exp_run.period + 4, 1'b0, at);
      check_step_gap(track_types_pkg::period_t'(at - prev_at), exp_run.period);
    end

    // reverse at full rate, new dir from the next boundary
    take_bits(9, r);
    s       = `SAMPLE_W'(`X0 - `DX2 - r);
    prev_p  = exp_run.period;
    exp_run = model_cmd(s, 1'b1);
    send_sample(s, 1'b1, 2'd1);
    wait_drain(30);
    wait_step(prev_p + 4, 1'b1, at);
    got.dir    = dir;
    got.active = drive_enable;
    check_drive(got, exp_run);
    repeat (3)
    begin
      prev_at = at;
      wait_step(exp_run.period + 4, 1'b0, at);
      check_step_gap(track_types_pkg::period_t'(at - prev_at), exp_run.period);
    end

    // dead band edge while running
    s = `SAMPLE_W'(`X0 + `DX1);
    send_sample(s, 1'b1, 2'd1);
    wait_drain(30);
    wait_disabled(1010);
    quiet_window(9000);

    $display("sim passed");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+verilog
verilog/track_types_pkg.sv
verilog/drive_types_pkg.sv
verilog/error_stage.sv
verilog/rate_stage.sv
verilog/period_divider.sv
verilog/step_pulse_gen.sv
verilog/tracker_top.sv
bench/tb_clock.sv
bench/tracker_tb.sv

// File: Bender.yml
package:
  name: stepper_tracker

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/track_types_pkg.sv
      - verilog/drive_types_pkg.sv
      - verilog/error_stage.sv
      - verilog/rate_stage.sv
      - verilog/period_divider.sv
      - verilog/step_pulse_gen.sv
      - verilog/tracker_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tb_clock.sv
      - bench/tracker_tb.sv
